/* source/ccip_sniffer_params.svh */
`ifndef CCIP_SNIFFER_PARAMS_SVH
`define CCIP_SNIFFER_PARAMS_SVH

// Cache-line address width, CCI-P default build
`define CCIP_ADDR_WIDTH 42

// Request metadata tag, returned unchanged with the response
`define CCIP_MDATA_WIDTH 16

// MMIO transaction ID, one tracker entry per value
`define CCIP_TID_WIDTH 9

// MMIO read response data word
`define CCIP_DATA_WIDTH 64

// Cycles allowed from MMIO read request to its response
`define MMIO_RSP_TIMEOUT 512
// Must hold MMIO_RSP_TIMEOUT without wrapping
`define MMIO_TIMER_WIDTH 10

// One bit per protocol rule
`define SNIFF_VECTOR_WIDTH 22

`endif

/* source/ccip_sniffer_pkg.sv */
`include "ccip_sniffer_params.svh"

package ccip_sniffer_pkg;

   // Channel 0 read types, other 4-bit codes are illegal
   typedef enum logic [3:0] {
      RDLINE_I = 4'h0,
      RDLINE_S = 4'h1
   } c0_req_t;

   // Channel 1 write and fence types
   typedef enum logic [3:0] {
      WRLINE_I = 4'h0,
      WRLINE_M = 4'h1,
      WRPUSH_I = 4'h2,
      WRFENCE  = 4'h4
   } c1_req_t;

   // cl_len encoding: 00 one line, 01 two, 10 three (illegal), 11 four
   typedef struct packed {
      logic [1:0]                   vc_sel;
      logic [1:0]                   cl_len;
      c0_req_t                      req_type;
      logic [`CCIP_ADDR_WIDTH-1:0]  address;
      logic [`CCIP_MDATA_WIDTH-1:0] mdata;
   } c0_req_hdr_t;

   // Write header, sop marks the first beat of a packet
   typedef struct packed {
      logic [1:0]                   vc_sel;
      logic                         sop;
      logic [1:0]                   cl_len;
      c1_req_t                      req_type;
      logic [`CCIP_ADDR_WIDTH-1:0]  address;
      logic [`CCIP_MDATA_WIDTH-1:0] mdata;
   } c1_req_hdr_t;

   typedef struct packed {
      logic [`CCIP_TID_WIDTH-1:0] tid;
   } mmio_rsp_hdr_t;

   typedef struct packed {
      logic        valid;
      c0_req_hdr_t hdr;
   } c0_beat_t;

   typedef struct packed {
      logic        valid;
      c1_req_hdr_t hdr;
   } c1_beat_t;

   // MMIO read response from the accelerator
   typedef struct packed {
      logic                        mmio_rd_valid;
      mmio_rsp_hdr_t               hdr;
      logic [`CCIP_DATA_WIDTH-1:0] data;
   } c2_beat_t;

   // MMIO read request seen on receive channel 0
   typedef struct packed {
      logic                       valid;
      logic [`CCIP_TID_WIDTH-1:0] tid;
   } mmio_req_t;

   // Bit index of each rule in the error vector
   typedef enum logic [4:0] {
      C0_INVALID_REQTYPE = 5'd0,
      C0_OVERFLOW        = 5'd1,
      C0_3CL             = 5'd2,
      C0_ALIGN2          = 5'd3,
      C0_ALIGN4          = 5'd4,
      C0_ADDR_ZERO       = 5'd5,
      C1_INVALID_REQTYPE = 5'd6,
      C1_OVERFLOW        = 5'd7,
      C1_3CL             = 5'd8,
      C1_ALIGN2          = 5'd9,
      C1_ALIGN4          = 5'd10,
      C1_ADDR_ZERO       = 5'd11,
      C1_SOP_NOT_SET     = 5'd12,
      C1_SOP_IN_MCL      = 5'd13,
      C1_UNEXP_ADDR      = 5'd14,
      C1_UNEXP_VCSEL     = 5'd15,
      C1_UNEXP_MDATA     = 5'd16,
      C1_UNEXP_CLLEN     = 5'd17,
      C1_UNEXP_REQTYPE   = 5'd18,
      C1_WRFENCE_IN_MCL  = 5'd19,
      MMIO_TIMEOUT       = 5'd20,
      MMIO_UNSOLICITED   = 5'd21
   } sniff_code_t;

   typedef logic [`SNIFF_VECTOR_WIDTH-1:0] sniff_vec_t;

endpackage

/* source/tx_sampler.sv */
`timescale 1ns/100ps

module tx_sampler
   import ccip_sniffer_pkg::*;
(
   input  logic      clk,
   input  logic      ase_reset,
   input  logic      soft_reset,
   input  c0_beat_t  c0_tx,
   input  c1_beat_t  c1_tx,
   input  c2_beat_t  c2_tx,
   input  mmio_req_t mmio_req,
   input  logic      c0_full,
   input  logic      c1_full,
   output c0_beat_t  c0_s,
   output c1_beat_t  c1_s,
   output c2_beat_t  c2_s,
   output mmio_req_t mmio_req_s,
   output logic      c0_full_s,
   output logic      c1_full_s,
   output logic      soft_reset_s
);

   // Single snapshot stage of every observed channel
   always_ff @(posedge clk) begin
      // Headers and data follow the inputs every cycle
      c0_s.hdr       <= c0_tx.hdr;
      c1_s.hdr       <= c1_tx.hdr;
      c2_s.hdr       <= c2_tx.hdr;
      c2_s.data      <= c2_tx.data;
      mmio_req_s.tid <= mmio_req.tid;

      // Qualifiers cleared so nothing downstream sees a phantom beat
      if (ase_reset) begin
         c0_s.valid          <= 1'b0;
         c1_s.valid          <= 1'b0;
         c2_s.mmio_rd_valid  <= 1'b0;
         mmio_req_s.valid    <= 1'b0;
         c0_full_s           <= 1'b0;
         c1_full_s           <= 1'b0;
         soft_reset_s        <= 1'b0;
      end else begin
         c0_s.valid          <= c0_tx.valid;
         c1_s.valid          <= c1_tx.valid;
         c2_s.mmio_rd_valid  <= c2_tx.mmio_rd_valid;
         mmio_req_s.valid    <= mmio_req.valid;
         c0_full_s           <= c0_full;
         c1_full_s           <= c1_full;
         // Soft reset travels with the beats
         soft_reset_s        <= soft_reset;
      end
   end

endmodule

/* source/c0_read_checker.sv */
`timescale 1ns/100ps

module c0_read_checker
   import ccip_sniffer_pkg::*;
(
   input  logic       clk,
   input  logic       ase_reset,
   input  logic       soft_reset_s,
   input  c0_beat_t   c0_s,
   input  logic       c0_full_s,
   output sniff_vec_t c0_flags
);

   logic       is_read;
   logic       rd_beat;
   sniff_vec_t flags_d;

   // Only the two read types are legal here
   assign is_read = c0_s.hdr.req_type inside {RDLINE_S, RDLINE_I};
   // Length and address rules apply to real reads only
   assign rd_beat = c0_s.valid && is_read;

   always_comb begin
      flags_d = '0;

      // Undefined type code on a valid beat
      flags_d[C0_INVALID_REQTYPE] = c0_s.valid && !is_read;
      // Host reported channel 0 full
      flags_d[C0_OVERFLOW]        = c0_s.valid && c0_full_s;

      // Three-line reads do not exist
      flags_d[C0_3CL]    = rd_beat && (c0_s.hdr.cl_len == 2'b10);
      // Two-line read needs an even base
      flags_d[C0_ALIGN2] = rd_beat && (c0_s.hdr.cl_len == 2'b01)
                           && c0_s.hdr.address[0];
      // Four-line read needs a base on a multiple of four
      flags_d[C0_ALIGN4] = rd_beat && (c0_s.hdr.cl_len == 2'b11)
                           && (c0_s.hdr.address[1:0] != 2'b00);

      // Line zero is never a valid target
      flags_d[C0_ADDR_ZERO] = rd_beat && (c0_s.hdr.address == '0);
   end

   // One-cycle pulse per offending beat
   always_ff @(posedge clk) begin
      if (ase_reset || soft_reset_s) begin
         c0_flags <= '0;
      end else begin
         c0_flags <= flags_d;
      end
   end

endmodule

/* source/c1_write_checker.sv */
`timescale 1ns/100ps
`include "ccip_sniffer_params.svh"

module c1_write_checker
   import ccip_sniffer_pkg::*;
(
   input  logic       clk,
   input  logic       ase_reset,
   input  logic       soft_reset_s,
   input  c1_beat_t   c1_s,
   input  logic       c1_full_s,
   output sniff_vec_t c1_flags
);

   // Encoding equals the beat index inside the packet
   typedef enum logic [1:0] {
      IDLE  = 2'd0,
      BEAT2 = 2'd1,
      BEAT3 = 2'd2,
      BEAT4 = 2'd3
   } pkt_state_t;

   pkt_state_t                   state;
   pkt_state_t                   state_nxt;

   // First-beat fields of the open packet
   logic [1:0]                   base_addr;
   logic [1:0]                   base_vc;
   logic [1:0]                   base_len;
   logic [`CCIP_MDATA_WIDTH-1:0] base_mdata;
   c1_req_t                      base_type;

   logic                         is_write;
   logic                         is_fence;
   logic                         first_beat;
   logic                         mcl_beat;
   logic [1:0]                   exp_addr;
   sniff_vec_t                   flags_d;

   assign is_write = c1_s.hdr.req_type inside {WRLINE_I, WRLINE_M, WRPUSH_I};
   assign is_fence = c1_s.hdr.req_type == WRFENCE;

   // Start of a packet, single-line or multi-line
   assign first_beat = c1_s.valid && is_write && c1_s.hdr.sop && (state == IDLE);
   // Any non-fence beat while a packet is open
   assign mcl_beat   = c1_s.valid && !is_fence && (state != IDLE);

   // Low address bits walk up by one per beat
   assign exp_addr = base_addr + 2'(state);

   always_comb begin
      flags_d = '0;

      flags_d[C1_INVALID_REQTYPE] = c1_s.valid && !is_write && !is_fence;
      flags_d[C1_OVERFLOW]        = c1_s.valid && c1_full_s;

      // First-beat length and address rules
      flags_d[C1_3CL]       = first_beat && (c1_s.hdr.cl_len == 2'b10);
      flags_d[C1_ALIGN2]    = first_beat && (c1_s.hdr.cl_len == 2'b01)
                              && c1_s.hdr.address[0];
      flags_d[C1_ALIGN4]    = first_beat && (c1_s.hdr.cl_len == 2'b11)
                              && (c1_s.hdr.address[1:0] != 2'b00);
      flags_d[C1_ADDR_ZERO] = first_beat && (c1_s.hdr.address == '0);

      // Write outside a packet without sop
      flags_d[C1_SOP_NOT_SET] = c1_s.valid && is_write && !c1_s.hdr.sop
                                && (state == IDLE);

      // Later beats must repeat the first-beat fields
      flags_d[C1_SOP_IN_MCL]    = mcl_beat && c1_s.hdr.sop;
      flags_d[C1_UNEXP_ADDR]    = mcl_beat && (c1_s.hdr.address[1:0] != exp_addr);
      flags_d[C1_UNEXP_VCSEL]   = mcl_beat && (c1_s.hdr.vc_sel != base_vc);
      flags_d[C1_UNEXP_MDATA]   = mcl_beat && (c1_s.hdr.mdata != base_mdata);
      flags_d[C1_UNEXP_CLLEN]   = mcl_beat && (c1_s.hdr.cl_len != base_len);
      flags_d[C1_UNEXP_REQTYPE] = mcl_beat && (c1_s.hdr.req_type != base_type);

      // Fence may only sit between packets
      flags_d[C1_WRFENCE_IN_MCL] = c1_s.valid && is_fence && (state != IDLE);
   end

   // Packet FSM, fences hold the state
   always_comb begin
      state_nxt = state;
      case (state)
         IDLE: begin
            if (first_beat && c1_s.hdr.cl_len[0]) begin
               state_nxt = BEAT2;
            end
         end
         BEAT2: begin
            // Two-line packet ends here
            if (mcl_beat) begin
               state_nxt = (base_len == 2'b11) ? BEAT3 : IDLE;
            end
         end
         BEAT3: begin
            if (mcl_beat) begin
               state_nxt = BEAT4;
            end
         end
         default: begin
            if (mcl_beat) begin
               state_nxt = IDLE;
            end
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (ase_reset || soft_reset_s) begin
         state    <= IDLE;
         c1_flags <= '0;
      end else begin
         state    <= state_nxt;
         c1_flags <= flags_d;
      end
   end

   // Reference fields latched on every packet start
   always_ff @(posedge clk) begin
      if (first_beat) begin
         base_addr  <= c1_s.hdr.address[1:0];
         base_vc    <= c1_s.hdr.vc_sel;
         base_len   <= c1_s.hdr.cl_len;
         base_mdata <= c1_s.hdr.mdata;
         base_type  <= c1_s.hdr.req_type;
      end
   end

endmodule

/* source/mmio_rsp_tracker.sv */
`timescale 1ns/100ps
`include "ccip_sniffer_params.svh"

module mmio_rsp_tracker
   import ccip_sniffer_pkg::*;
(
   input  logic       clk,
   input  logic       ase_reset,
   input  logic       soft_reset_s,
   input  mmio_req_t  mmio_req_s,
   input  c2_beat_t   c2_s,
   output sniff_vec_t mmio_flags
);

   localparam int TRACK_DEPTH = 1 << `CCIP_TID_WIDTH;
   localparam logic [`MMIO_TIMER_WIDTH-1:0] TIMEOUT_VAL =
      `MMIO_TIMER_WIDTH'(`MMIO_RSP_TIMEOUT);

   // One entry per TID
   logic [TRACK_DEPTH-1:0]       active;
   logic [TRACK_DEPTH-1:0]       timed_out;
   logic [`MMIO_TIMER_WIDTH-1:0] timer [TRACK_DEPTH];

   logic [TRACK_DEPTH-1:0]       expire;
   logic                         expire_any;
   logic                         unsolicited;

   // Entry hits the limit for the first time
   always_comb begin
      for (int i = 0; i < TRACK_DEPTH; i++) begin
         expire[i] = active[i] && !timed_out[i] && (timer[i] == TIMEOUT_VAL);
      end
   end

   // Response to a TID with nothing outstanding
   assign unsolicited = c2_s.mmio_rd_valid && !active[c2_s.hdr.tid];

   // Request after response, so a same-cycle reuse stays open
   always_ff @(posedge clk) begin
      if (ase_reset || soft_reset_s) begin
         active <= '0;
      end else begin
         if (c2_s.mmio_rd_valid) begin
            active[c2_s.hdr.tid] <= 1'b0;
         end
         if (mmio_req_s.valid) begin
            active[mmio_req_s.tid] <= 1'b1;
         end
      end
   end

   // Timers restart on request and saturate at the limit
   always_ff @(posedge clk) begin
      for (int i = 0; i < TRACK_DEPTH; i++) begin
         if (mmio_req_s.valid && (mmio_req_s.tid == `CCIP_TID_WIDTH'(i))) begin
            timer[i]     <= '0;
            timed_out[i] <= 1'b0;
         end else if (active[i]) begin
            if (timer[i] != TIMEOUT_VAL) begin
               timer[i] <= timer[i] + 1'b1;
            end
            // Report each late TID once
            if (expire[i]) begin
               timed_out[i] <= 1'b1;
            end
         end
      end
   end

   // Wide OR over all TIDs gets its own stage
   always_ff @(posedge clk) begin
      if (ase_reset || soft_reset_s) begin
         expire_any <= 1'b0;
         mmio_flags <= '0;
      end else begin
         expire_any                   <= |expire;
         mmio_flags                   <= '0;
         mmio_flags[MMIO_TIMEOUT]     <= expire_any;
         mmio_flags[MMIO_UNSOLICITED] <= unsolicited;
      end
   end

endmodule

/* source/error_reporter.sv */
`timescale 1ns/100ps

module error_reporter
   import ccip_sniffer_pkg::*;
(
   input  logic       clk,
   input  logic       ase_reset,
   input  logic       soft_reset_s,
   input  sniff_vec_t c0_flags,
   input  sniff_vec_t c1_flags,
   input  sniff_vec_t mmio_flags,
   output sniff_vec_t error_code
);

   // Soft reset aligned with the checker stage
   logic soft_reset_q;

   always_ff @(posedge clk) begin
      if (ase_reset) begin
         soft_reset_q <= 1'b0;
      end else begin
         soft_reset_q <= soft_reset_s;
      end
   end

   // Sticky OR of all checker pulses
   always_ff @(posedge clk) begin
      if (ase_reset || soft_reset_q) begin
         error_code <= '0;
      end else begin
         // Each checker owns disjoint bits
         error_code <= error_code | c0_flags | c1_flags | mmio_flags;
      end
   end

endmodule

/* source/ccip_sniffer.sv */
`timescale 1ns/100ps

module ccip_sniffer
   import ccip_sniffer_pkg::*;
(
   input  logic       clk,
   input  logic       ase_reset,
   input  logic       soft_reset,
   input  c0_beat_t   c0_tx,
   input  c1_beat_t   c1_tx,
   input  c2_beat_t   c2_tx,
   input  mmio_req_t  mmio_req,
   input  logic       c0_full,
   input  logic       c1_full,
   output sniff_vec_t error_code
);

   // Sampled channels
   c0_beat_t   c0_s;
   c1_beat_t   c1_s;
   c2_beat_t   c2_s;
   mmio_req_t  mmio_req_s;
   logic       c0_full_s;
   logic       c1_full_s;
   logic       soft_reset_s;

   // Per-checker pulse vectors
   sniff_vec_t c0_flags;
   sniff_vec_t c1_flags;
   sniff_vec_t mmio_flags;

   tx_sampler u_tx_sampler (
      .clk          (clk),
      .ase_reset    (ase_reset),
      .soft_reset   (soft_reset),
      .c0_tx        (c0_tx),
      .c1_tx        (c1_tx),
      .c2_tx        (c2_tx),
      .mmio_req     (mmio_req),
      .c0_full      (c0_full),
      .c1_full      (c1_full),
      .c0_s         (c0_s),
      .c1_s         (c1_s),
      .c2_s         (c2_s),
      .mmio_req_s   (mmio_req_s),
      .c0_full_s    (c0_full_s),
      .c1_full_s    (c1_full_s),
      .soft_reset_s (soft_reset_s)
   );

   c0_read_checker u_c0_read_checker (
      .clk          (clk),
      .ase_reset    (ase_reset),
      .soft_reset_s (soft_reset_s),
      .c0_s         (c0_s),
      .c0_full_s    (c0_full_s),
      .c0_flags     (c0_flags)
   );

   c1_write_checker u_c1_write_checker (
      .clk          (clk),
      .ase_reset    (ase_reset),
      .soft_reset_s (soft_reset_s),
      .c1_s         (c1_s),
      .c1_full_s    (c1_full_s),
      .c1_flags     (c1_flags)
   );

   mmio_rsp_tracker u_mmio_rsp_tracker (
      .clk          (clk),
      .ase_reset    (ase_reset),
      .soft_reset_s (soft_reset_s),
      .mmio_req_s   (mmio_req_s),
      .c2_s         (c2_s),
      .mmio_flags   (mmio_flags)
   );

   error_reporter u_error_reporter (
      .clk          (clk),
      .ase_reset    (ase_reset),
      .soft_reset_s (soft_reset_s),
      .c0_flags     (c0_flags),
      .c1_flags     (c1_flags),
      .mmio_flags   (mmio_flags),
      .error_code   (error_code)
   );

endmodule

/* tb/tb_ccip_sniffer.sv */
`timescale 1ns/100ps
`include "ccip_sniffer_params.svh"

module tb_ccip_sniffer
   import ccip_sniffer_pkg::*;
();

   localparam int          RESET_CYCLES = 16;
   localparam int          CHECK_DELAY  = 4;
   localparam int          MAX_LINES    = 1000;
   localparam int          MAX_IDLE     = 2000;
   localparam int unsigned SEED         = 32'h73cd;

   logic       clk = 1'b0;
   logic       ase_reset;
   logic       soft_reset;
   c0_beat_t   c0_tx;
   c1_beat_t   c1_tx;
   c2_beat_t   c2_tx;
   mmio_req_t  mmio_req;
   logic       c0_full;
   logic       c1_full;
   sniff_vec_t error_code;

   // 8 ns clock
   always #4 clk = ~clk;

   ccip_sniffer uut (
      .clk        (clk),
      .ase_reset  (ase_reset),
      .soft_reset (soft_reset),
      .c0_tx      (c0_tx),
      .c1_tx      (c1_tx),
      .c2_tx      (c2_tx),
      .mmio_req   (mmio_req),
      .c0_full    (c0_full),
      .c1_full    (c1_full),
      .error_code (error_code)
   );

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("Simulation finished: FAIL");
      $fatal(1);
   endtask

   // Drop every qualifier, headers keep their last value
   task automatic release_inputs();
      c0_tx.valid        <= 1'b0;
      c1_tx.valid        <= 1'b0;
      c2_tx.mmio_rd_valid <= 1'b0;
      mmio_req.valid     <= 1'b0;
      c0_full            <= 1'b0;
      c1_full            <= 1'b0;
      soft_reset         <= 1'b0;
   endtask

   task automatic step_cycle();
      @(posedge clk);
      release_inputs();
   endtask

   // Bounded by the caller's count
   task automatic idle_cycles(input int count);
      for (int i = 0; i < count; i++) begin
         step_cycle();
      end
   endtask

   task automatic drive_c0(input logic [1:0] vc, input logic [1:0] len, input c0_req_t typ,
                           input logic [`CCIP_ADDR_WIDTH-1:0] addr,
                           input logic [`CCIP_MDATA_WIDTH-1:0] mdata, input logic full);
      step_cycle();
      c0_tx.valid        <= 1'b1;
      c0_tx.hdr.vc_sel   <= vc;
      c0_tx.hdr.cl_len   <= len;
      c0_tx.hdr.req_type <= typ;
      c0_tx.hdr.address  <= addr;
      c0_tx.hdr.mdata    <= mdata;
      c0_full            <= full;
   endtask

   task automatic drive_c1(input logic [1:0] vc, input logic sop, input logic [1:0] len,
                           input c1_req_t typ, input logic [`CCIP_ADDR_WIDTH-1:0] addr,
                           input logic [`CCIP_MDATA_WIDTH-1:0] mdata, input logic full);
      step_cycle();
      c1_tx.valid        <= 1'b1;
      c1_tx.hdr.vc_sel   <= vc;
      c1_tx.hdr.sop      <= sop;
      c1_tx.hdr.cl_len   <= len;
      c1_tx.hdr.req_type <= typ;
      c1_tx.hdr.address  <= addr;
      c1_tx.hdr.mdata    <= mdata;
      c1_full            <= full;
   endtask

   // Pipeline drains, then error_code is read away from the active edge
   task automatic check_vector(input reg [8*32-1:0] name, input sniff_vec_t expected);
      idle_cycles(CHECK_DELAY);
      @(negedge clk);
      assert (error_code === expected) else begin
         $display("Error: test %0s expected %h actual %h", name, expected, error_code);
         $display("Simulation finished: FAIL");
         $fatal(1);
      end
   endtask

   initial begin
      int                           fd;
      int                           n;
      int                           lines;
      int                           checks;
      reg [8*128-1:0]               line;
      reg [8*16-1:0]                kind;
      reg [8*32-1:0]                f_name;
      logic [1:0]                   f_vc;
      logic                         f_sop;
      logic [1:0]                   f_len;
      logic [3:0]                   f_type;
      logic [`CCIP_ADDR_WIDTH-1:0]  f_addr;
      logic [`CCIP_MDATA_WIDTH-1:0] f_mdata;
      logic                         f_full;
      logic [`CCIP_TID_WIDTH-1:0]   f_tid;
      logic [`CCIP_DATA_WIDTH-1:0]  f_data;
      int                           f_count;
      sniff_vec_t                   f_exp;

      void'($urandom(SEED));
      lines  = 0;
      checks = 0;

      ase_reset  = 1'b1;
      soft_reset = 1'b0;
      c0_tx      = '0;
      c1_tx      = '0;
      c2_tx      = '0;
      mmio_req   = '0;
      c0_full    = 1'b0;
      c1_full    = 1'b0;

      for (int i = 0; i < RESET_CYCLES; i++) begin
         @(posedge clk);
      end
      ase_reset <= 1'b0;

      fd = $fopen("tb/sniffer_golden.txt", "r");
      if (fd == 0) begin
         fail_run("Cannot open tb/sniffer_golden.txt");
      end

      while (!$feof(fd)) begin
         if (lines >= MAX_LINES) begin
            fail_run("Golden file has more lines than allowed");
         end
         lines++;
         line = '0;
         kind = '0;
         n = $fgets(line, fd);
         if (n > 0) begin
            n = $sscanf(line, "%s", kind);
         end
         // Blank and comment lines carry no record
         if (n < 1 || kind == "#") begin
            n = 0;
         end else if (kind == "c0") begin
            n = $sscanf(line, "%s %h %h %h %h %h %h", kind, f_vc, f_len, f_type,
                        f_addr, f_mdata, f_full);
            if (n != 7) fail_run($sformatf("Malformed c0 record on line %0d", lines));
            idle_cycles($urandom_range(0, 2));
            drive_c0(f_vc, f_len, c0_req_t'(f_type), f_addr, f_mdata, f_full);
         end else if (kind == "c1") begin
            n = $sscanf(line, "%s %h %h %h %h %h %h %h", kind, f_vc, f_sop, f_len,
                        f_type, f_addr, f_mdata, f_full);
            if (n != 8) fail_run($sformatf("Malformed c1 record on line %0d", lines));
            idle_cycles($urandom_range(0, 2));
            drive_c1(f_vc, f_sop, f_len, c1_req_t'(f_type), f_addr, f_mdata, f_full);
         end else if (kind == "mreq") begin
            n = $sscanf(line, "%s %h", kind, f_tid);
            if (n != 2) fail_run($sformatf("Malformed mreq record on line %0d", lines));
            idle_cycles($urandom_range(0, 2));
            step_cycle();
            mmio_req.valid <= 1'b1;
            mmio_req.tid   <= f_tid;
         end else if (kind == "mrsp") begin
            n = $sscanf(line, "%s %h %h", kind, f_tid, f_data);
            if (n != 3) fail_run($sformatf("Malformed mrsp record on line %0d", lines));
            idle_cycles($urandom_range(0, 2));
            step_cycle();
            c2_tx.mmio_rd_valid <= 1'b1;
            c2_tx.hdr.tid       <= f_tid;
            c2_tx.data          <= f_data;
         end else if (kind == "idle") begin
            n = $sscanf(line, "%s %d", kind, f_count);
            if (n != 2 || f_count < 0 || f_count > MAX_IDLE) begin
               fail_run($sformatf("Bad idle count on line %0d", lines));
            end
            idle_cycles(f_count);
         end else if (kind == "softreset") begin
            idle_cycles($urandom_range(0, 2));
            step_cycle();
            soft_reset <= 1'b1;
         end else if (kind == "check") begin
            n = $sscanf(line, "%s %s %h", kind, f_name, f_exp);
            if (n != 3) fail_run($sformatf("Malformed check record on line %0d", lines));
            check_vector(f_name, f_exp);
            checks++;
         end else begin
            fail_run($sformatf("Unknown record kind on line %0d", lines));
         end
      end
      $fclose(fd);

      if (checks == 0) begin
         fail_run("Golden file holds no check records");
      end else begin
         $display("Simulation finished: PASS");
         $finish;
      end
   end

endmodule

/* ccip_sniffer.f */
+incdir+source
source/ccip_sniffer_pkg.sv
source/tx_sampler.sv
source/c0_read_checker.sv
source/c1_write_checker.sv
source/mmio_rsp_tracker.sv
source/error_reporter.sv
source/ccip_sniffer.sv
tb/tb_ccip_sniffer.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the CCI-P checker testbench with Verilator and runs it from the project root

set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir
FAIL_MSG="Simulation finished: FAIL"
PASS_MSG="Simulation finished: PASS"

verilator --binary --timing --assert -Wno-fatal --top-module tb_ccip_sniffer \
   -Mdir "$BUILD_DIR" -f ccip_sniffer.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"./$BUILD_DIR/Vtb_ccip_sniffer" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -qF "$FAIL_MSG" "$LOG"; then
   echo "Testbench reported a failure, see $LOG"
   exit 1
fi
if [ $run_status -ne 0 ]; then
   echo "Simulation exited with status $run_status"
   exit 1
fi
if ! grep -qF "$PASS_MSG" "$LOG"; then
   echo "Simulation ended without a result line"
   exit 1
fi
exit 0

/* tb/sniffer_golden.txt */
# c0 vc cl_len type addr mdata full | c1 vc sop cl_len type addr mdata full | mreq tid
# mrsp tid data | idle cycles | softreset | check name expected_error_code, all hex but idle
check after_reset 000000
# Legal writes, fence between packets, reads and an answered MMIO read
c1 0 1 0 0 100 0001 0
c1 1 1 3 1 200 0002 0
c1 1 0 3 1 201 0002 0
c1 1 0 3 1 202 0002 0
c1 1 0 3 1 203 0002 0
c1 0 0 0 4 000 0003 0
c1 0 1 1 2 300 0004 0
c1 0 0 1 2 301 0004 0
c0 0 0 1 040 0010 0
c0 0 3 0 044 0011 0
c0 0 1 1 046 0012 0
mreq 005
mrsp 005 0123456789abcdef
check legal_traffic 000000
# Channel 0 read rules
c0 0 0 7 080 0020 0
check c0_bad_type 000001
softreset
c0 0 2 0 084 0021 0
check c0_three_line 000004
softreset
c0 0 1 0 085 0022 0
check c0_align2 000008
softreset
c0 0 3 1 086 0023 0
check c0_align4 000010
softreset
c0 0 0 0 000 0024 0
check c0_addr_zero 000020
softreset
c0 0 0 0 088 0025 1
check c0_overflow 000002
softreset
# Channel 1 multi-line packet rules
c1 0 0 0 0 400 0030 0
check c1_no_sop 001000
softreset
c1 0 1 1 0 410 0031 0
c1 0 1 1 0 411 0031 0
check c1_sop_beat2 002000
softreset
c1 0 1 3 0 420 0032 0
c1 0 0 3 0 421 0032 0
c1 0 0 3 0 423 0032 0
c1 0 0 3 0 423 0032 0
check c1_bad_incr 004000
softreset
c1 0 1 1 0 430 0033 0
c1 2 0 1 0 431 0033 0
check c1_vc_change 008000
softreset
c1 0 1 1 0 440 0034 0
c1 0 0 1 0 441 0035 0
check c1_mdata_change 010000
softreset
c1 0 1 1 0 450 0036 0
c1 0 0 3 0 451 0036 0
check c1_len_change 020000
softreset
c1 0 1 1 0 460 0037 0
c1 0 0 1 1 461 0037 0
check c1_type_change 040000
softreset
c1 0 1 1 0 470 0038 0
c1 0 0 0 4 000 0039 0
c1 0 0 1 0 471 0038 0
check c1_fence_in_pkt 080000
softreset
# Channel 1 first-beat rules
c1 0 1 2 0 500 0040 0
check c1_three_line 000100
softreset
c1 0 1 1 0 501 0041 0
c1 0 0 1 0 502 0041 0
check c1_align2 000200
softreset
c1 0 1 3 0 506 0042 0
c1 0 0 3 0 507 0042 0
c1 0 0 3 0 508 0042 0
c1 0 0 3 0 509 0042 0
check c1_align4 000400
softreset
c1 0 1 0 0 000 0043 0
check c1_addr_zero 000800
softreset
c1 0 1 0 7 510 0044 0
check c1_bad_type 000040
softreset
c1 0 1 0 0 520 0045 1
check c1_overflow 000080
softreset
# MMIO response tracking
mrsp 011 00000000cafef00d
check mmio_unsolicited 200000
softreset
mreq 012
idle 530
check mmio_timeout 100000
# Sticky bits survive legal traffic and merge with new errors
c1 0 1 0 0 600 0050 0
c0 0 0 0 604 0051 0
check sticky_hold 100000
c0 0 2 0 608 0052 0
check sticky_merge 100004
softreset
check soft_reset_clear 000000
